// ==== list.f ====
rtl/spi_cmd_pkg.sv
rtl/pulse_param_pkg.sv
rtl/spi_byte_link.sv
rtl/feedback_capture.sv
rtl/spi_cmd_decoder.sv
rtl/ack_stretch.sv
rtl/spi_cmd_top.sv
sim/tb_clk_gen.sv
sim/spi_cmd_props.sv
sim/spi_cmd_tb.sv

// ==== rtl/ack_stretch.sv ====
`timescale 1ns/1ps

module ack_stretch
#(
    parameter int ACK_HOLD = 4
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic pulse,
    output logic ack
);

    localparam int CNT_W = $clog2(ACK_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;

    // a fresh pulse restarts the hold
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            hold_cnt <= '0;
        else if (pulse)
            hold_cnt <= CNT_W'(ACK_HOLD);
        else if (hold_cnt != '0)
            hold_cnt <= hold_cnt - 1'b1;
    end

    assign ack = (hold_cnt != '0);

endmodule

// ==== rtl/feedback_capture.sv ====
`timescale 1ns/1ps

module feedback_capture
#(
    parameter int SYNC_STAGES = 3
)
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 feedback_valid,
    input  logic                                 frame_active,
    input  logic [pulse_param_pkg::FEEDBACK_W-1:0] feedback_data,
    output logic [pulse_param_pkg::FEEDBACK_W-1:0] feedback_word
);

    logic [SYNC_STAGES-1:0] valid_sync;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_sync <= '0;
        else
            valid_sync <= {valid_sync[SYNC_STAGES-2:0], feedback_valid};
    end

    // frozen while a frame is running
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            feedback_word <= '0;
        else if (!frame_active && valid_sync[SYNC_STAGES-1])
            feedback_word <= feedback_data;
    end

endmodule

// ==== rtl/pulse_param_pkg.sv ====
package pulse_param_pkg;

    localparam int SETTING_W  = 16;
    localparam int FEEDBACK_W = 32;

    // power-up pulse settings
    localparam logic [SETTING_W-1:0] TON_RESET  = 16'd80;
    localparam logic [SETTING_W-1:0] TOFF_RESET = 16'd20;
    localparam logic [SETTING_W-1:0] IP_RESET   = 16'd30;
    localparam logic [SETTING_W-1:0] WAVE_RESET = 16'd0;

endpackage

// ==== rtl/spi_byte_link.sv ====
`timescale 1ns/1ps

module spi_byte_link
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    input  logic [7:0] tx_byte,
    output logic       miso,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_active
);

    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_n_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;

    // sclk idles high in mode 3
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sclk_sync <= 2'b11;
            mosi_sync <= 2'b00;
            cs_n_sync <= 2'b11;
            sclk_prev <= 1'b1;
        end
        else
        begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            cs_n_sync <= {cs_n_sync[0], cs_n};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign frame_active = ~cs_n_sync[1];
    assign sclk_rise    = frame_active & sclk_sync[1] & ~sclk_prev;
    assign sclk_fall    = frame_active & ~sclk_sync[1] & sclk_prev;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            if (!frame_active)
                bit_cnt <= 3'd0;
            else if (sclk_rise)
            begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sclk_rise)
        begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7)
                rx_byte <= {rx_shift, mosi_sync[1]};
        end
    end

    // first falling edge of a byte loads, later ones shift
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            tx_shift <= 8'hFF;
        else if (!frame_active)
            tx_shift <= 8'hFF;
        else if (sclk_fall)
            tx_shift <= (bit_cnt == 3'd0) ? tx_byte : {tx_shift[6:0], 1'b1};
    end

    assign miso = tx_shift[7];

endmodule

// ==== rtl/spi_cmd_decoder.sv ====
`timescale 1ns/1ps

module spi_cmd_decoder
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [7:0]                             rx_byte,
    input  logic                                   rx_valid,
    input  logic                                   frame_active,
    input  logic [pulse_param_pkg::FEEDBACK_W-1:0] feedback_word,
    output logic [pulse_param_pkg::SETTING_W-1:0]  ton,
    output logic [pulse_param_pkg::SETTING_W-1:0]  toff,
    output logic [pulse_param_pkg::SETTING_W-1:0]  ip,
    output logic [pulse_param_pkg::SETTING_W-1:0]  waveform,
    output logic                                   start_pulse,
    output logic                                   stop_pulse,
    output logic                                   ton_pulse,
    output logic                                   toff_pulse,
    output logic                                   ip_pulse,
    output logic                                   wave_pulse,
    output logic [7:0]                             tx_byte,
    output logic                                   feedback_done
);

    spi_cmd_pkg::cmd_state_e state;
    logic [1:0]              sel;
    logic [1:0]              byte_idx;
    logic [7:0]              stage;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= spi_cmd_pkg::ST_IDLE;
            sel           <= 2'd0;
            byte_idx      <= 2'd0;
            ton           <= pulse_param_pkg::TON_RESET;
            toff          <= pulse_param_pkg::TOFF_RESET;
            ip            <= pulse_param_pkg::IP_RESET;
            waveform      <= pulse_param_pkg::WAVE_RESET;
            start_pulse   <= 1'b0;
            stop_pulse    <= 1'b0;
            ton_pulse     <= 1'b0;
            toff_pulse    <= 1'b0;
            ip_pulse      <= 1'b0;
            wave_pulse    <= 1'b0;
            feedback_done <= 1'b0;
        end
        else
        begin
            start_pulse   <= (state == spi_cmd_pkg::ST_START);
            stop_pulse    <= (state == spi_cmd_pkg::ST_STOP);
            ton_pulse     <= 1'b0;
            toff_pulse    <= 1'b0;
            ip_pulse      <= 1'b0;
            wave_pulse    <= 1'b0;
            feedback_done <= 1'b0;
            // early cs_n rise drops whatever was pending
            if (!frame_active)
                state <= spi_cmd_pkg::ST_IDLE;
            else
            begin
                case (state)
                    spi_cmd_pkg::ST_IDLE:
                        if (rx_valid)
                        begin
                            byte_idx <= 2'd0;
                            case (rx_byte)
                                spi_cmd_pkg::OP_START:    state <= spi_cmd_pkg::ST_START;
                                spi_cmd_pkg::OP_STOP:     state <= spi_cmd_pkg::ST_STOP;
                                spi_cmd_pkg::OP_FEEDBACK: state <= spi_cmd_pkg::ST_READBACK;
                                spi_cmd_pkg::OP_TON,
                                spi_cmd_pkg::OP_TOFF,
                                spi_cmd_pkg::OP_IP,
                                spi_cmd_pkg::OP_WAVE:
                                begin
                                    state <= spi_cmd_pkg::ST_SET_LO;
                                    case (rx_byte)
                                        spi_cmd_pkg::OP_TON:  sel <= 2'd0;
                                        spi_cmd_pkg::OP_TOFF: sel <= 2'd1;
                                        spi_cmd_pkg::OP_IP:   sel <= 2'd2;
                                        default:              sel <= 2'd3;
                                    endcase
                                end
                                default: state <= spi_cmd_pkg::ST_IDLE;
                            endcase
                        end
                    spi_cmd_pkg::ST_SET_LO:
                        if (rx_valid)
                            state <= spi_cmd_pkg::ST_SET_HI;
                    spi_cmd_pkg::ST_SET_HI:
                        if (rx_valid)
                        begin
                            state <= spi_cmd_pkg::ST_IDLE;
                            case (sel)
                                2'd0:
                                begin
                                    ton       <= {rx_byte, stage};
                                    ton_pulse <= 1'b1;
                                end
                                2'd1:
                                begin
                                    toff       <= {rx_byte, stage};
                                    toff_pulse <= 1'b1;
                                end
                                2'd2:
                                begin
                                    ip       <= {rx_byte, stage};
                                    ip_pulse <= 1'b1;
                                end
                                default:
                                begin
                                    waveform   <= {rx_byte, stage};
                                    wave_pulse <= 1'b1;
                                end
                            endcase
                        end
                    spi_cmd_pkg::ST_READBACK:
                        if (rx_valid)
                        begin
                            byte_idx <= byte_idx + 2'd1;
                            if (byte_idx == 2'(spi_cmd_pkg::READBACK_BYTES - 1))
                            begin
                                state         <= spi_cmd_pkg::ST_IDLE;
                                feedback_done <= 1'b1;
                            end
                        end
                    default:
                        state <= spi_cmd_pkg::ST_IDLE;
                endcase
            end
        end
    end

    // low data byte waits here for its partner
    always_ff @(posedge clk)
    begin
        if (state == spi_cmd_pkg::ST_SET_LO && rx_valid)
            stage <= rx_byte;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            tx_byte <= 8'hFF;
        else if (state == spi_cmd_pkg::ST_READBACK)
            tx_byte <= feedback_word[{byte_idx, 3'b000} +: 8];
        else
            tx_byte <= 8'hFF;
    end

endmodule

// ==== rtl/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

    // command bytes sent by the SPI master
    typedef enum logic [7:0] {
        OP_START    = 8'h06,
        OP_STOP     = 8'h04,
        OP_TON      = 8'h91,
        OP_TOFF     = 8'h9E,
        OP_IP       = 8'h93,
        OP_WAVE     = 8'h9C,
        OP_FEEDBACK = 8'hAB
    } opcode_e;

    // decoder FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_STOP,
        ST_SET_LO,
        ST_SET_HI,
        ST_READBACK
    } cmd_state_e;

    // bytes shifted out during a readback
    localparam int READBACK_BYTES = 4;

endpackage

// ==== rtl/spi_cmd_top.sv ====
`timescale 1ns/1ps

module spi_cmd_top
#(
    parameter int ACK_HOLD    = 4,
    parameter int SYNC_STAGES = 3
)
(
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   sclk,
    input  logic                                   mosi,
    input  logic                                   cs_n,
    input  logic                                   feedback_valid,
    input  logic [pulse_param_pkg::FEEDBACK_W-1:0] feedback_data,
    output logic                                   miso,
    output logic [pulse_param_pkg::SETTING_W-1:0]  ton,
    output logic [pulse_param_pkg::SETTING_W-1:0]  toff,
    output logic [pulse_param_pkg::SETTING_W-1:0]  ip,
    output logic [pulse_param_pkg::SETTING_W-1:0]  waveform,
    output logic                                   start_ack,
    output logic                                   stop_ack,
    output logic                                   ton_ack,
    output logic                                   toff_ack,
    output logic                                   ip_ack,
    output logic                                   waveform_ack,
    output logic                                   feedback_done
);

    logic [7:0]                             rx_byte;
    logic                                   rx_valid;
    logic                                   frame_active;
    logic [7:0]                             tx_byte;
    logic [pulse_param_pkg::FEEDBACK_W-1:0] feedback_word;
    logic [5:0]                             pulses;
    logic [5:0]                             acks;

    spi_byte_link link_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .sclk         (sclk),
        .mosi         (mosi),
        .cs_n         (cs_n),
        .tx_byte      (tx_byte),
        .miso         (miso),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .frame_active (frame_active)
    );

    feedback_capture #(.SYNC_STAGES(SYNC_STAGES)) capture_i
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .feedback_valid (feedback_valid),
        .frame_active   (frame_active),
        .feedback_data  (feedback_data),
        .feedback_word  (feedback_word)
    );

    spi_cmd_decoder decoder_i
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .frame_active  (frame_active),
        .feedback_word (feedback_word),
        .ton           (ton),
        .toff          (toff),
        .ip            (ip),
        .waveform      (waveform),
        .start_pulse   (pulses[0]),
        .stop_pulse    (pulses[1]),
        .ton_pulse     (pulses[2]),
        .toff_pulse    (pulses[3]),
        .ip_pulse      (pulses[4]),
        .wave_pulse    (pulses[5]),
        .tx_byte       (tx_byte),
        .feedback_done (feedback_done)
    );

    // one stretcher per acknowledge
    for (genvar i = 0; i < 6; i++)
    begin : g_ack
        ack_stretch #(.ACK_HOLD(ACK_HOLD)) stretch_i
        (
            .clk   (clk),
            .rst_n (rst_n),
            .pulse (pulses[i]),
            .ack   (acks[i])
        );
    end

    assign {waveform_ack, ip_ack, toff_ack, ton_ack, stop_ack, start_ack} = acks;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spi_cmd_tb -f list.f -o spi_cmd_sim

output=$(./obj_dir/spi_cmd_sim 2>&1) || true
echo "$output"

if grep -qx "Regression passed" <<< "$output"
then
    exit 0
fi
exit 1

// ==== sim/spi_cmd_props.sv ====
`timescale 1ns/1ps

module spi_cmd_props
#(
    parameter int ACK_HOLD = 4
)
(
    input logic                    clk,
    input logic                    rst_n,
    input logic                    frame_active,
    input spi_cmd_pkg::cmd_state_e state,
    input logic [5:0]              pulses,
    input logic                    feedback_done,
    input logic                    pulse,
    input logic                    ack
);

    pulses_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(pulses))
        else $error("more than one command pulse in the same cycle");

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        feedback_done |=> !feedback_done)
        else $error("feedback_done high for more than one cycle");

    // ack rises right after the pulse and is still up ACK_HOLD cycles later
    ack_starts: assert property (@(posedge clk) disable iff (!rst_n)
        $past(pulse) |-> ack)
        else $error("ack not raised after pulse");

    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        $past(pulse, ACK_HOLD) |-> ack)
        else $error("ack dropped before ACK_HOLD cycles");

    idle_outside_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !frame_active |=> state == spi_cmd_pkg::ST_IDLE)
        else $error("decoder not idle after frame end");

endmodule

bind spi_cmd_decoder spi_cmd_props decoder_props_i
(
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_active  (frame_active),
    .state         (state),
    .pulses        ({wave_pulse, ip_pulse, toff_pulse, ton_pulse, stop_pulse, start_pulse}),
    .feedback_done (feedback_done),
    .pulse         (1'b0),
    .ack           (1'b0)
);

// decoder side tied off here
bind ack_stretch spi_cmd_props #(.ACK_HOLD(ACK_HOLD)) stretch_props_i
(
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_active  (1'b1),
    .state         (spi_cmd_pkg::ST_IDLE),
    .pulses        (6'b000000),
    .feedback_done (1'b0),
    .pulse         (pulse),
    .ack           (ack)
);

// ==== sim/spi_cmd_tb.sv ====
`timescale 1ns/1ps

module spi_cmd_tb;

    localparam int ACK_HOLD       = 4;
    localparam int SYNC_STAGES    = 3;
    localparam int HALF_SCLK      = 4;
    localparam int TIMEOUT_CYCLES = 20000;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   sclk;
    logic                                   mosi;
    logic                                   cs_n;
    logic                                   feedback_valid;
    logic [pulse_param_pkg::FEEDBACK_W-1:0] feedback_data;
    logic                                   miso;
    logic [pulse_param_pkg::SETTING_W-1:0]  settings [4];
    logic                                   start_ack;
    logic                                   stop_ack;
    logic                                   ton_ack;
    logic                                   toff_ack;
    logic                                   ip_ack;
    logic                                   waveform_ack;
    logic                                   feedback_done;
    logic [5:0]                             acks;

    // reference model state
    logic [15:0] exp_set [4];
    logic [31:0] exp_fb;
    logic [5:0]  exp_ack_mask;
    logic [7:0]  exp_miso [5];
    int          exp_done_cnt;

    // observed during a frame
    logic [7:0]  got_miso [5];
    int          n_bytes;
    logic [5:0]  seen_mask;
    int          run_len [6];
    int          done_cnt;
    logic        compare_req;

    int          errors;
    int          tests;
    int          cycles;
    string       ack_name [6];
    string       set_name [4];

    tb_clk_gen #(.PERIOD_NS(4)) clk_gen_i (.clk(clk));

    spi_cmd_top #(.ACK_HOLD(ACK_HOLD), .SYNC_STAGES(SYNC_STAGES)) dut_i
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .sclk           (sclk),
        .mosi           (mosi),
        .cs_n           (cs_n),
        .feedback_valid (feedback_valid),
        .feedback_data  (feedback_data),
        .miso           (miso),
        .ton            (settings[0]),
        .toff           (settings[1]),
        .ip             (settings[2]),
        .waveform       (settings[3]),
        .start_ack      (start_ack),
        .stop_ack       (stop_ack),
        .ton_ack        (ton_ack),
        .toff_ack       (toff_ack),
        .ip_ack         (ip_ack),
        .waveform_ack   (waveform_ack),
        .feedback_done  (feedback_done)
    );

    assign acks = {waveform_ack, ip_ack, toff_ack, ton_ack, stop_ack, start_ack};

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    function automatic void model_frame(input logic [7:0] op, input logic [7:0] lo,
                                        input logic [7:0] hi, input int n);
        int sel;
        sel = -1;
        exp_ack_mask = '0;
        exp_done_cnt = 0;
        for (int k = 0; k < 5; k++)
            exp_miso[k] = 8'hFF;
        case (op)
            spi_cmd_pkg::OP_START:    exp_ack_mask[0] = 1'b1;
            spi_cmd_pkg::OP_STOP:     exp_ack_mask[1] = 1'b1;
            spi_cmd_pkg::OP_TON:      sel = 0;
            spi_cmd_pkg::OP_TOFF:     sel = 1;
            spi_cmd_pkg::OP_IP:       sel = 2;
            spi_cmd_pkg::OP_WAVE:     sel = 3;
            spi_cmd_pkg::OP_FEEDBACK:
            begin
                // dummy byte k carries feedback byte k-1
                for (int k = 1; k < n && k <= 4; k++)
                    exp_miso[k] = exp_fb[8*(k-1) +: 8];
                if (n >= 5)
                    exp_done_cnt = 1;
            end
            default:
                sel = -1;
        endcase
        // written only once the high byte is in
        if (sel >= 0 && n >= 3)
        begin
            exp_set[sel] = {hi, lo};
            exp_ack_mask[sel + 2] = 1'b1;
        end
    endfunction

    // mode 3 drives on the falling sclk edge and samples on the rising one
    task automatic spi_byte(input logic [7:0] out, output logic [7:0] in);
        for (int b = 7; b >= 0; b--)
        begin
            sclk = 1'b0;
            mosi = out[b];
            repeat (HALF_SCLK) @(negedge clk);
            in[b] = miso;
            sclk = 1'b1;
            repeat (HALF_SCLK) @(negedge clk);
        end
    endtask

    task automatic settle_and_compare();
        int guard;
        guard = 0;
        while (((seen_mask & exp_ack_mask) != exp_ack_mask || acks != '0) && guard < 40)
        begin
            @(negedge clk);
            guard++;
        end
        if (guard >= 40)
        begin
            $display("acknowledge missing or stuck high 40 cycles after the frame");
            errors++;
        end
        compare_req = 1'b1;
        while (compare_req)
            @(negedge clk);
    endtask

    task automatic run_frame(input logic [7:0] op, input logic [7:0] lo,
                             input logic [7:0] hi, input int n);
        logic [7:0] bytes [5];
        bytes = '{op, lo, hi, 8'h00, 8'h00};
        model_frame(op, lo, hi, n);
        n_bytes = n;
        @(negedge clk);
        cs_n = 1'b0;
        repeat (HALF_SCLK) @(negedge clk);
        for (int k = 0; k < n; k++)
            spi_byte(bytes[k], got_miso[k]);
        cs_n = 1'b1;
        repeat (2 * HALF_SCLK) @(negedge clk);
        settle_and_compare();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // ack lengths, ack set, done count, settings and miso bytes
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            for (int i = 0; i < 6; i++)
            begin
                if (acks[i])
                begin
                    if (run_len[i] == 0)
                        seen_mask[i] = 1'b1;
                    run_len[i]++;
                end
                else if (run_len[i] != 0)
                begin
                    if (run_len[i] != ACK_HOLD)
                        report_mismatch({ack_name[i], " cycles"}, 32'(run_len[i]), ACK_HOLD);
                    run_len[i] = 0;
                end
            end
            if (feedback_done)
                done_cnt++;
        end
        if (compare_req)
        begin
            for (int s = 0; s < 4; s++)
                if (settings[s] !== exp_set[s])
                    report_mismatch(set_name[s], 32'(settings[s]), 32'(exp_set[s]));
            if (seen_mask !== exp_ack_mask)
                report_mismatch("acks", 32'(seen_mask), 32'(exp_ack_mask));
            if (done_cnt != exp_done_cnt)
                report_mismatch("feedback_done pulses", 32'(done_cnt), 32'(exp_done_cnt));
            for (int k = 0; k < n_bytes; k++)
                if (got_miso[k] !== exp_miso[k])
                    report_mismatch($sformatf("miso byte %0d", k), 32'(got_miso[k]),
                                    32'(exp_miso[k]));
            seen_mask = '0;
            done_cnt = 0;
            compare_req = 1'b0;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d clock cycles, test sequence did not finish", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin
        int          mark;
        logic [15:0] value;
        logic [7:0]  set_op [4];
        void'($urandom(43985));
        ack_name = '{"start_ack", "stop_ack", "ton_ack", "toff_ack", "ip_ack", "waveform_ack"};
        set_name = '{"ton", "toff", "ip", "waveform"};
        set_op = '{spi_cmd_pkg::OP_TON, spi_cmd_pkg::OP_TOFF, spi_cmd_pkg::OP_IP,
                   spi_cmd_pkg::OP_WAVE};
        rst_n = 1'b0;
        sclk = 1'b1;
        mosi = 1'b0;
        cs_n = 1'b1;
        feedback_valid = 1'b0;
        feedback_data = '0;
        errors = 0;
        tests = 0;
        cycles = 0;
        compare_req = 1'b0;
        seen_mask = '0;
        done_cnt = 0;
        n_bytes = 0;
        run_len = '{0, 0, 0, 0, 0, 0};
        exp_set = '{pulse_param_pkg::TON_RESET, pulse_param_pkg::TOFF_RESET,
                    pulse_param_pkg::IP_RESET, pulse_param_pkg::WAVE_RESET};
        exp_fb = '0;
        exp_ack_mask = '0;
        exp_done_cnt = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        repeat (2) @(negedge clk);
        if (miso !== 1'b1)
            report_mismatch("miso", 32'(miso), 32'h1);
        if (acks !== '0)
            report_mismatch("acks", 32'(acks), 32'h0);
        if (feedback_done !== 1'b0)
            report_mismatch("feedback_done", 32'(feedback_done), 32'h0);
        settle_and_compare();
        finish_test("reset", mark);

        mark = errors;
        run_frame(spi_cmd_pkg::OP_START, 8'h00, 8'h00, 1);
        run_frame(spi_cmd_pkg::OP_STOP, 8'h00, 8'h00, 1);
        finish_test("start_stop", mark);

        mark = errors;
        for (int s = 0; s < 4; s++)
        begin
            value = 16'($urandom);
            run_frame(set_op[s], value[7:0], value[15:8], 3);
        end
        finish_test("setting_writes", mark);

        mark = errors;
        exp_fb = $urandom;
        feedback_data = exp_fb;
        feedback_valid = 1'b1;
        repeat (SYNC_STAGES + 3) @(negedge clk);
        feedback_valid = 1'b0;
        repeat (SYNC_STAGES + 3) @(negedge clk);
        run_frame(spi_cmd_pkg::OP_FEEDBACK, 8'h00, 8'h00, 5);
        finish_test("readback", mark);

        mark = errors;
        run_frame(8'h55, 8'h00, 8'h00, 2);
        // ip command cut off after its low byte and then a full one
        value = 16'($urandom);
        run_frame(spi_cmd_pkg::OP_IP, value[7:0], value[15:8], 2);
        value = 16'($urandom);
        run_frame(spi_cmd_pkg::OP_IP, value[7:0], value[15:8], 3);
        finish_test("robustness", mark);

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter int PERIOD_NS = 4
)
(
    output logic clk
);

    initial
        clk = 1'b0;

    always
        #(PERIOD_NS / 2.0) clk = ~clk;

endmodule
